// ==== files.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/data_mem.sv
verilog/uart_dump.sv
verilog/soc_top.sv
verif/clk_gen.sv
verif/soc_assert.sv
verif/soc_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the SoC testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module soc_tb -o soc_sim \
	&& ./obj_dir/soc_sim > sim.log 2>&1 || echo "build or run failed"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/soc_tb.sv ====
/*
 * SoC testbench
 * Random RV32I programs, reference model, UART byte sampler and timeout
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module soc_tb;

	localparam int DEPTH = 2 ** `IMEM_AW;
	localparam int FRAME = 10 * `BAUD_DIV;
	localparam int NPROG = 6;
	// Load, run and up to three frames per program
	localparam int LIMIT = NPROG * (2 * DEPTH + 3 * FRAME + 64) + 200;

	logic                 clk;
	logic                 gen_rst_n;
	logic                 tb_rst_n;
	logic                 arst_n;
	logic                 run;
	logic                 prog_we;
	logic [`IMEM_AW-1:0]  prog_addr;
	logic [`XLEN-1:0]     prog_data;
	logic                 uart_tx;
	logic                 int_o;

	logic [31:0]  lfsr = 32'd52;
	logic [31:0]  prog [DEPTH];
	int           plen;
	int           chk_reg;
	logic [31:0]  m_rf [32];
	logic [31:0]  m_mem [64];
	logic [7:0]   exp_q [$];
	logic [7:0]   rx_q [$];
	int           int_cnt = 0;
	int           cycles = 0;
	string        test_name = "reset";

	clk_gen u_clk (.clk_o(clk), .rst_n_o(gen_rst_n));

	assign arst_n = gen_rst_n & tb_rst_n;

	soc_top DUT (
		.CLK_BUF     (clk),
		.arst_n_i    (arst_n),
		.run_i       (run),
		.prog_we_i   (prog_we),
		.prog_addr_i (prog_addr),
		.prog_data_i (prog_data),
		.uart_tx_o   (uart_tx),
		.int_o       (int_o)
	);

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic fail_plain(string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_int_count(string name, int exp, int act);
		if (exp != act) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// Galois LFSR, one step per bit
	function automatic int take_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | int'(lfsr[0]);
			if (lfsr[0]) lfsr = (lfsr >> 1) ^ 32'h8020_0003;
			else lfsr = lfsr >> 1;
		end
		return r;
	endfunction

	// Instruction encoders
	function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic void emit(logic [31:0] w);
		prog[plen] = w;
		plen++;
	endfunction

	function automatic void clear_program();
		plen = 0;
		for (int i = 0; i < DEPTH; i++) prog[i] = 32'h0000_0013;
	endfunction

	// Random ALU ops over x0..x8, writes only x1..x8
	function automatic void add_random_alu(int n);
		int sel;
		int rd;
		int rs1;
		int rs2;
		for (int i = 0; i < n; i++) begin
			sel = take_bits(3) % 6;
			rd  = take_bits(3) + 1;
			rs1 = take_bits(4) % 9;
			rs2 = take_bits(4) % 9;
			case (sel)
				0: emit(enc_i(take_bits(12), rs1, 0, rd, 7'h13));
				1: emit(enc_r(0, rs2, rs1, 0, rd));
				2: emit(enc_r(7'h20, rs2, rs1, 0, rd));
				3: emit(enc_r(0, rs2, rs1, 4, rd));
				4: emit(enc_r(0, rs2, rs1, 6, rd));
				default: emit(enc_r(0, rs2, rs1, 7, rd));
			endcase
		end
	endfunction

	// Low byte of src with the valid bit, stored to the mailbox
	function automatic void add_mailbox(int src);
		emit(enc_i(255, 0, 0, 30, 7'h13));
		emit(enc_i(1 << `TX_VALID_BIT, 0, 0, 31, 7'h13));
		emit(enc_r(0, 30, src, 7, 29));
		emit(enc_r(0, 31, 29, 6, 29));
		emit(enc_s(`TX_MAILBOX_ADDR * 4, 29, 0));
		chk_reg = src;
	endfunction

	// Sequential ISA model, fills exp_q with the mailbox bytes
	function automatic void run_model();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] res;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic        wr;
		for (int i = 0; i < 32; i++) m_rf[i] = '0;
		for (int pc = 0; pc < DEPTH; pc++) begin
			w   = prog[pc];
			opc = w[6:0];
			f3  = w[14:12];
			f7  = w[31:25];
			a   = m_rf[w[19:15]];
			b   = m_rf[w[24:20]];
			wr  = 1'b1;
			res = '0;
			case (opc)
				7'h13: begin
					if (f3 == 3'd0) res = a + {{20{w[31]}}, w[31:20]};
					else wr = 1'b0;
				end
				7'h33: begin
					if (f3 == 3'd0 && f7 == 7'h00) res = a + b;
					else if (f3 == 3'd0 && f7 == 7'h20) res = a - b;
					else if (f3 == 3'd4 && f7 == 7'h00) res = a ^ b;
					else if (f3 == 3'd6 && f7 == 7'h00) res = a | b;
					else if (f3 == 3'd7 && f7 == 7'h00) res = a & b;
					else wr = 1'b0;
				end
				7'h03: begin
					addr = a + {{20{w[31]}}, w[31:20]};
					if (f3 == 3'd2) res = m_mem[addr[7:2]];
					else wr = 1'b0;
				end
				7'h23: begin
					wr   = 1'b0;
					addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
					if (f3 == 3'd2) begin
						m_mem[addr[7:2]] = b;
						if (addr[7:2] == 6'(`TX_MAILBOX_ADDR) && b[`TX_VALID_BIT])
							exp_q.push_back(b[7:0]);
					end
				end
				default: wr = 1'b0;
			endcase
			if (wr && w[11:7] != 5'd0) m_rf[w[11:7]] = res;
		end
	endfunction

	task automatic load_program();
		for (int i = 0; i < DEPTH; i++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= `IMEM_AW'(i);
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	// Load, run until every expected interrupt, then check and reset
	task automatic run_program(string name);
		int nexp;
		int base;
		test_name = name;
		exp_q.delete();
		run_model();
		nexp = exp_q.size();
		load_program();
		base = int_cnt;
		@(posedge clk);
		run <= 1'b1;
		while (int_cnt - base < nexp) @(posedge clk);
		repeat (4) @(posedge clk);
		check_int_count(name, nexp, int_cnt - base);
		if (exp_q.size() != 0) fail_plain({name, ": expected UART bytes never arrived"});
		check_word(name, m_rf[chk_reg], DUT.u_writeback.rf[chk_reg]);
		run <= 1'b0;
		tb_rst_n <= 1'b0;
		repeat (2) @(posedge clk);
		tb_rst_n <= 1'b1;
	endtask

	// UART sampler, starts on the first low cycle of a start bit
	initial begin : uart_sampler
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (arst_n && !uart_tx) begin
				for (int i = 0; i < 8; i++) begin
					repeat (`BAUD_DIV) @(negedge clk);
					b[i] = uart_tx;
				end
				repeat (`BAUD_DIV) @(negedge clk);
				if (!uart_tx) fail_plain("UART stop bit was low");
				rx_q.push_back(b);
			end
		end
	end

	initial begin : int_counter
		forever begin
			@(negedge clk);
			if (int_o) int_cnt++;
		end
	end

	// Received bytes against the model, in order
	initial begin : byte_compare
		forever begin
			@(negedge clk);
			while (rx_q.size() != 0) begin
				if (exp_q.size() == 0) fail_plain("UART sent a byte that no store requested");
				else check_byte(test_name, exp_q.pop_front(), rx_q.pop_front());
			end
		end
	end

	initial begin : timeout
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT) fail_plain("Timeout: run did not finish in time");
		end
	end

	initial begin
		tb_rst_n  = 1'b1;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		for (int i = 0; i < 64; i++) m_mem[i] = '0;
		@(posedge gen_rst_n);
		// Idle line with the core stopped
		repeat (40) begin
			@(negedge clk);
			if (!uart_tx || int_o) fail_plain("UART or interrupt active before run");
		end
		for (int p = 0; p < 3; p++) begin
			clear_program();
			add_random_alu(30);
			add_mailbox(take_bits(3) + 1);
			run_program("alu_random");
		end
		// Store, load and dependent add back to back
		clear_program();
		emit(enc_i(take_bits(12), 0, 0, 5, 7'h13));
		emit(enc_i(take_bits(12), 0, 0, 6, 7'h13));
		emit(enc_s((take_bits(5) % 32) * 4, 5, 0));
		emit(enc_i(prog[2][11:7] | (prog[2][31:25] << 5), 0, 2, 7, 7'h03));
		emit(enc_r(0, 6, 7, 0, 8));
		add_mailbox(8);
		run_program("load_forward");
		// x0 targets and encodings outside the subset
		clear_program();
		add_random_alu(10);
		emit(enc_i(take_bits(12), 0, 0, 1, 7'h37));
		emit(enc_i(3, 2, 1, 2, 7'h13));
		emit(enc_r(1, 4, 3, 0, 3));
		emit(enc_i(7, 1, 0, 4, 7'h63));
		emit(enc_r(0, 3, 2, 0, 0));
		emit(enc_i(55, 1, 0, 0, 7'h13));
		// Fold x0 and every skipped target into x5, right behind the x0 write
		emit(enc_r(0, 0, 1, 0, 5));
		emit(enc_r(0, 4, 5, 0, 5));
		emit(enc_r(0, 2, 5, 4, 5));
		emit(enc_r(7'h20, 3, 5, 0, 5));
		add_mailbox(5);
		run_program("x0_and_illegal");
		// Three mailbox stores, 50 words apart
		clear_program();
		for (int k = 0; k < 3; k++) begin
			add_random_alu(10);
			add_mailbox(take_bits(3) + 1);
			plen = (k + 1) * 50;
		end
		run_program("multi_byte");
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verif/soc_assert.sv ====
/*
 * SoC assertions
 * Interrupt width, idle line level and valid flags under reset
 */
`timescale 1ns/100ps

module soc_assert (
	input logic                CLK_BUF,
	input logic                arst_n_i,
	input logic                int_i,
	input logic                uart_tx_i,
	input rv_pkg::uart_state_e state_i,
	input logic                fe_valid_i,
	input logic                wb_valid_i
);

	// Completion pulse is a single cycle
	int_one_cycle: assert property (@(posedge CLK_BUF) disable iff (!arst_n_i)
		int_i |=> !int_i)
		else $error("int_o held longer than one cycle");

	// Line idles high
	tx_idle_high: assert property (@(posedge CLK_BUF) disable iff (!arst_n_i)
		(state_i == rv_pkg::IDLE) |-> uart_tx_i)
		else $error("uart_tx_o low while controller idle");

	// Pipeline empty while in reset
	no_valid_in_reset: assert property (@(posedge CLK_BUF)
		!arst_n_i |-> (!fe_valid_i && !wb_valid_i))
		else $error("pipeline valid set during reset");

endmodule

bind soc_top soc_assert u_assert (
	.CLK_BUF    (CLK_BUF),
	.arst_n_i   (arst_n_i),
	.int_i      (int_o),
	.uart_tx_i  (uart_tx_o),
	.state_i    (u_uart.state),
	.fe_valid_i (fe_if.valid),
	.wb_valid_i (wb_if.valid)
);

// ==== verif/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, reset held low for the first two cycles
 */
`timescale 1ns/100ps

module clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Release after two rising edges
	initial begin
		repeat (2) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== verilog/soc_top.sv ====
/*
 * SoC top level
 * Three-stage RV32I core, shared data memory and UART dump controller
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module soc_top (
	input  logic                 CLK_BUF,
	input  logic                 arst_n_i,
	input  logic                 run_i,
	// Program load port
	input  logic                 prog_we_i,
	input  logic [`IMEM_AW-1:0]  prog_addr_i,
	input  logic [`XLEN-1:0]     prog_data_i,
	output logic                 uart_tx_o,
	output logic                 int_o
);

	// Pipeline and memory bundles
	fetch_ex_if   fe_if ();
	ex_wb_if      wb_if ();
	dmem_port_if  port_a ();
	dmem_port_if  port_b ();

	// Register file reads
	logic [4:0]        rs1_addr;
	logic [4:0]        rs2_addr;
	logic [`XLEN-1:0]  rs1_data;
	logic [`XLEN-1:0]  rs2_data;

	// Writeback to execute forwarding
	logic              wb_we;
	logic [4:0]        wb_rd;
	logic [`XLEN-1:0]  wb_data;

	fetch_stage u_fetch (
		.CLK_BUF     (CLK_BUF),
		.arst_n_i    (arst_n_i),
		.run_i       (run_i),
		.prog_we_i   (prog_we_i),
		.prog_addr_i (prog_addr_i),
		.prog_data_i (prog_data_i),
		.fe_if       (fe_if.master)
	);

	execute_stage u_execute (
		.CLK_BUF    (CLK_BUF),
		.arst_n_i   (arst_n_i),
		.fe_if      (fe_if.slave),
		.wb_if      (wb_if.master),
		.mem_if     (port_a.master),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.wb_we_i    (wb_we),
		.wb_rd_i    (wb_rd),
		.wb_data_i  (wb_data)
	);

	// Load data returns on port A in the writeback cycle
	writeback_stage u_writeback (
		.CLK_BUF     (CLK_BUF),
		.arst_n_i    (arst_n_i),
		.wb_if       (wb_if.slave),
		.load_data_i (port_a.rdata),
		.rs1_addr_i  (rs1_addr),
		.rs2_addr_i  (rs2_addr),
		.rs1_data_o  (rs1_data),
		.rs2_data_o  (rs2_data),
		.wb_we_o     (wb_we),
		.wb_rd_o     (wb_rd),
		.wb_data_o   (wb_data)
	);

	data_mem u_dmem (
		.CLK_BUF (CLK_BUF),
		.a       (port_a.slave),
		.b       (port_b.slave)
	);

	uart_dump u_uart (
		.CLK_BUF   (CLK_BUF),
		.arst_n_i  (arst_n_i),
		.mem_if    (port_b.master),
		.uart_tx_o (uart_tx_o),
		.int_o     (int_o)
	);

endmodule

// ==== verilog/uart_dump.sv ====
/*
 * UART dump controller
 * Polls the mailbox word, sends its byte and raises an interrupt when done
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module uart_dump (
	input  logic         CLK_BUF,
	input  logic         arst_n_i,
	dmem_port_if.master  mem_if,
	output logic         uart_tx_o,
	output logic         int_o
);

	localparam int BAUD_W = $clog2(`BAUD_DIV + 1);

	rv_pkg::uart_state_e  state;
	logic [BAUD_W-1:0]    baud_cnt;
	logic                 baud_last;
	logic [2:0]           bit_cnt;
	logic [7:0]           shreg;
	logic                 req;

	// Mailbox polled every cycle
	assign mem_if.addr  = `DMEM_AW'(`TX_MAILBOX_ADDR);
	assign mem_if.wdata = '0;

	// Valid bit seen while idle
	assign req = (state == rv_pkg::IDLE) && mem_if.rdata[`TX_VALID_BIT];

	// Clearing the mailbox accepts the request
	assign mem_if.we = req;

	// Last cycle of a bit period
	assign baud_last = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));

	always_ff @(posedge CLK_BUF or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state    <= rv_pkg::IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			int_o    <= 1'b0;
		end else begin
			int_o <= 1'b0;
			// Bit timer runs outside IDLE only
			if ((state == rv_pkg::IDLE) || baud_last) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
			case (state)
				rv_pkg::IDLE: begin
					if (req) state <= rv_pkg::START;
				end
				rv_pkg::START: begin
					if (baud_last) begin
						state   <= rv_pkg::DATA;
						bit_cnt <= '0;
					end
				end
				rv_pkg::DATA: begin
					if (baud_last) begin
						bit_cnt <= bit_cnt + 1'b1;
						// Eighth bit done
						if (bit_cnt == 3'd7) state <= rv_pkg::STOP;
					end
				end
				rv_pkg::STOP: begin
					if (baud_last) begin
						state <= rv_pkg::IDLE;
						// One-cycle completion pulse
						int_o <= 1'b1;
					end
				end
				default: state <= rv_pkg::IDLE;
			endcase
		end
	end

	// Byte buffer, LSB goes out first
	always_ff @(posedge CLK_BUF) begin
		if (req) begin
			shreg <= mem_if.rdata[7:0];
		end else if ((state == rv_pkg::DATA) && baud_last) begin
			shreg <= shreg >> 1;
		end
	end

	// Line level per state, idle high
	always_comb begin
		case (state)
			rv_pkg::START: uart_tx_o = 1'b0;
			rv_pkg::DATA:  uart_tx_o = shreg[0];
			default:       uart_tx_o = 1'b1;
		endcase
	end

endmodule

// ==== verilog/data_mem.sv ====
/*
 * Data memory
 * Two synchronous read/write word ports, port A wins a write collision
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module data_mem (
	input  logic         CLK_BUF,
	// Core port
	dmem_port_if.slave   a,
	// Controller port
	dmem_port_if.slave   b
);

	logic [`XLEN-1:0] mem [2**`DMEM_AW];
	logic             b_blocked;

	// Same-address write from both sides
	assign b_blocked = a.we && (a.addr == b.addr);

	// Writes
	always_ff @(posedge CLK_BUF) begin
		if (a.we) begin
			mem[a.addr] <= a.wdata;
		end
		if (b.we && !b_blocked) begin
			mem[b.addr] <= b.wdata;
		end
	end

	// Registered reads, old data on a same-cycle write
	always_ff @(posedge CLK_BUF) begin
		a.rdata <= mem[a.addr];
		b.rdata <= mem[b.addr];
	end

endmodule

// ==== verilog/writeback_stage.sv ====
/*
 * Writeback stage
 * Register file, load or ALU result select and forwarding source
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module writeback_stage (
	input  logic              CLK_BUF,
	input  logic              arst_n_i,
	ex_wb_if.slave            wb_if,
	// Port A read data for this instruction
	input  logic [`XLEN-1:0]  load_data_i,
	input  logic [4:0]        rs1_addr_i,
	input  logic [4:0]        rs2_addr_i,
	output logic [`XLEN-1:0]  rs1_data_o,
	output logic [`XLEN-1:0]  rs2_data_o,
	output logic              wb_we_o,
	output logic [4:0]        wb_rd_o,
	output logic [`XLEN-1:0]  wb_data_o
);

	// 32 entries, entry 0 is never written
	logic [`XLEN-1:0] rf [32];

	// Only register-writing ops, and never x0
	assign wb_we_o = wb_if.valid && (wb_if.op != rv_pkg::NOP) &&
	                 (wb_if.op != rv_pkg::SW) && (wb_if.rd != 5'd0);
	assign wb_rd_o = wb_if.rd;

	// Loads take memory data
	assign wb_data_o = (wb_if.op == rv_pkg::LW) ? load_data_i : wb_if.result;

	always_ff @(posedge CLK_BUF or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_we_o) begin
			rf[wb_rd_o] <= wb_data_o;
		end
	end

	// Combinational reads
	assign rs1_data_o = rf[rs1_addr_i];
	assign rs2_data_o = rf[rs2_addr_i];

endmodule

// ==== verilog/execute_stage.sv ====
/*
 * Execute stage
 * Decode, operand forwarding from writeback, ALU and data memory request
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module execute_stage (
	input  logic              CLK_BUF,
	input  logic              arst_n_i,
	fetch_ex_if.slave         fe_if,
	ex_wb_if.master           wb_if,
	dmem_port_if.master       mem_if,
	// Register file read
	output logic [4:0]        rs1_addr_o,
	output logic [4:0]        rs2_addr_o,
	input  logic [`XLEN-1:0]  rs1_data_i,
	input  logic [`XLEN-1:0]  rs2_data_i,
	// Forwarding source
	input  logic              wb_we_i,
	input  logic [4:0]        wb_rd_i,
	input  logic [`XLEN-1:0]  wb_data_i
);

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	rv_pkg::dec_t      dec;
	logic [`XLEN-1:0]  op_a;
	logic [`XLEN-1:0]  op_b;
	logic [`XLEN-1:0]  alu_result;

	assign opcode = fe_if.instr[6:0];
	assign funct3 = fe_if.instr[14:12];
	assign funct7 = fe_if.instr[31:25];

	// RV32I field decode
	always_comb begin
		dec.rd  = fe_if.instr[11:7];
		dec.rs1 = fe_if.instr[19:15];
		dec.rs2 = fe_if.instr[24:20];
		// I-type immediate by default
		dec.imm = {{(`XLEN-12){fe_if.instr[31]}}, fe_if.instr[31:20]};
		dec.op  = rv_pkg::NOP;
		if (fe_if.valid) begin
			case (opcode)
				7'b0010011: begin
					if (funct3 == 3'b000) dec.op = rv_pkg::ADDI;
				end
				7'b0110011: begin
					// Register ops, SUB marked by funct7 bit 5
					case (funct3)
						3'b000: begin
							if (funct7 == 7'b0000000) dec.op = rv_pkg::ADD;
							else if (funct7 == 7'b0100000) dec.op = rv_pkg::SUB;
						end
						3'b100: if (funct7 == 7'b0000000) dec.op = rv_pkg::XOR;
						3'b110: if (funct7 == 7'b0000000) dec.op = rv_pkg::OR;
						3'b111: if (funct7 == 7'b0000000) dec.op = rv_pkg::AND;
						default: dec.op = rv_pkg::NOP;
					endcase
				end
				7'b0000011: begin
					if (funct3 == 3'b010) dec.op = rv_pkg::LW;
				end
				7'b0100011: begin
					if (funct3 == 3'b010) dec.op = rv_pkg::SW;
					// S-type immediate
					dec.imm = {{(`XLEN-12){fe_if.instr[31]}},
					           fe_if.instr[31:25], fe_if.instr[11:7]};
				end
				default: dec.op = rv_pkg::NOP;
			endcase
		end
	end

	assign rs1_addr_o = dec.rs1;
	assign rs2_addr_o = dec.rs2;

	// Take the writeback value when it targets a source, x0 never forwards
	assign op_a = (wb_we_i && (wb_rd_i != 5'd0) && (wb_rd_i == dec.rs1)) ?
	              wb_data_i : rs1_data_i;
	assign op_b = (wb_we_i && (wb_rd_i != 5'd0) && (wb_rd_i == dec.rs2)) ?
	              wb_data_i : rs2_data_i;

	// ALU
	always_comb begin
		case (dec.op)
			rv_pkg::ADDI: alu_result = op_a + dec.imm;
			rv_pkg::ADD:  alu_result = op_a + op_b;
			rv_pkg::SUB:  alu_result = op_a - op_b;
			rv_pkg::XOR:  alu_result = op_a ^ op_b;
			rv_pkg::OR:   alu_result = op_a | op_b;
			rv_pkg::AND:  alu_result = op_a & op_b;
			// Byte address for loads and stores
			rv_pkg::LW,
			rv_pkg::SW:   alu_result = op_a + dec.imm;
			default:      alu_result = '0;
		endcase
	end

	// Word aligned data memory request in this cycle
	assign mem_if.addr  = alu_result[`DMEM_AW+1:2];
	assign mem_if.wdata = op_b;
	assign mem_if.we    = (dec.op == rv_pkg::SW);

	// Execute to writeback register
	always_ff @(posedge CLK_BUF or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_if.valid <= 1'b0;
		end else begin
			wb_if.valid <= fe_if.valid;
		end
	end

	always_ff @(posedge CLK_BUF) begin
		wb_if.op     <= dec.op;
		wb_if.rd     <= dec.rd;
		wb_if.result <= alu_result;
	end

endmodule

// ==== verilog/fetch_stage.sv ====
/*
 * Fetch stage
 * Instruction memory with load port, program counter and fetch register
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

module fetch_stage (
	input  logic                 CLK_BUF,
	input  logic                 arst_n_i,
	input  logic                 run_i,
	// Program load port
	input  logic                 prog_we_i,
	input  logic [`IMEM_AW-1:0]  prog_addr_i,
	input  logic [`XLEN-1:0]     prog_data_i,
	fetch_ex_if.master           fe_if
);

	// Instruction memory
	logic [`XLEN-1:0] imem [2**`IMEM_AW];

	// Word program counter
	logic [`IMEM_AW-1:0] pc;

	// Write-only load port
	always_ff @(posedge CLK_BUF) begin
		if (prog_we_i) begin
			imem[prog_addr_i] <= prog_data_i;
		end
	end

	// PC and valid flag
	always_ff @(posedge CLK_BUF or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc          <= '0;
			fe_if.valid <= 1'b0;
		end else begin
			// One instruction per cycle while running
			fe_if.valid <= run_i;
			// Park on the last word, which holds NOPs
			if (run_i && (pc != '1)) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Fetched word and its address
	always_ff @(posedge CLK_BUF) begin
		if (run_i) begin
			fe_if.instr <= imem[pc];
			fe_if.pc    <= pc;
		end
	end

endmodule

// ==== verilog/pipe_if.sv ====
/*
 * Pipeline and memory port bundles
 * Fetch to execute, execute to writeback and data memory ports
 */
`timescale 1ns/100ps
`include "soc_consts.svh"

// Fetch register contents
interface fetch_ex_if;
	logic                 valid;
	logic [`XLEN-1:0]     instr;
	// Word address of the instruction
	logic [`IMEM_AW-1:0]  pc;

	modport master (output valid, output instr, output pc);
	modport slave  (input valid, input instr, input pc);
endinterface

// Execute result register
interface ex_wb_if;
	logic              valid;
	rv_pkg::op_e       op;
	logic [4:0]        rd;
	// ALU result or load address
	logic [`XLEN-1:0]  result;

	modport master (output valid, output op, output rd, output result);
	modport slave  (input valid, input op, input rd, input result);
endinterface

// One port of the data memory
// Read data comes back one cycle after addr
interface dmem_port_if;
	logic [`DMEM_AW-1:0]  addr;
	logic [`XLEN-1:0]     wdata;
	logic                 we;
	logic [`XLEN-1:0]     rdata;

	modport master (output addr, output wdata, output we, input rdata);
	modport slave  (input addr, input wdata, input we, output rdata);
endinterface

// ==== verilog/rv_pkg.sv ====
/*
 * Core and controller types
 * Opcodes, UART FSM states and the decoded instruction record
 */
`include "soc_consts.svh"

package rv_pkg;

	// Supported operations
	// Anything not decoded runs as NOP
	typedef enum logic [3:0] {
		NOP,
		ADDI,
		ADD,
		SUB,
		XOR,
		OR,
		AND,
		LW,
		SW
	} op_e;

	// UART transmit FSM
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uart_state_e;

	// Decoded instruction fields
	typedef struct packed {
		op_e               op;
		logic [4:0]        rd;
		logic [4:0]        rs1;
		logic [4:0]        rs2;
		// Sign extended I or S immediate
		logic [`XLEN-1:0]  imm;
	} dec_t;

endpackage

// ==== verilog/soc_consts.svh ====
/*
 * SoC constants
 * Widths, memory depths, UART mailbox location and bit timing
 */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Data word width
`define XLEN 32

// Instruction memory word address width
`define IMEM_AW 8

// Data memory word address width
`define DMEM_AW 6

// Word address of the UART mailbox
`define TX_MAILBOX_ADDR 63

// Mailbox bit that requests a send
`define TX_VALID_BIT 8

// Clock cycles per UART bit
`define BAUD_DIV 4

`endif
